// ==== verilog/baser_tx_cfg.svh ====
// build-time settings; only 64-bit lanes and a 2-bit sync header are supported, gap fixed here
`ifndef BASER_TX_CFG_SVH
`define BASER_TX_CFG_SVH

// lane geometry
`define BASER_DATA_W 64
`define BASER_KEEP_W 8
`define BASER_HDR_W 2

// frame length including FCS, short frames are zero padded up to this
`define BASER_MIN_FRAME_LEN 64

// idle characters between terminate and next start
`define BASER_IFG_BYTES 12

// ethernet CRC-32, normal form, applied reflected
`define BASER_CRC_POLY 32'h04c11db7

// preamble and start frame delimiter
`define BASER_PRE 8'h55
`define BASER_SFD 8'hd5

`endif

// ==== verilog/baser_tx_pkg.sv ====
// shared types; block kind encodings keep the terminate byte count in the low three bits
`include "baser_tx_cfg.svh"

package baser_tx_pkg;

    // one frame word or block payload
    typedef logic [`BASER_DATA_W-1:0] word_t;

    // unused top bytes of a last word
    typedef logic [$clog2(`BASER_KEEP_W)-1:0] empty_t;

    // framer to encoder, term_n carries n data bytes
    typedef enum logic [3:0] {
        kind_idle   = 4'd0,
        kind_error  = 4'd1,
        kind_start  = 4'd2,
        kind_data   = 4'd4,
        kind_term_0 = 4'd8,
        kind_term_1 = 4'd9,
        kind_term_2 = 4'd10,
        kind_term_3 = 4'd11,
        kind_term_4 = 4'd12,
        kind_term_5 = 4'd13,
        kind_term_6 = 4'd14,
        kind_term_7 = 4'd15
    } block_kind_t;

    typedef enum logic [2:0] {
        state_idle,
        state_payload,
        state_pad,     // zero fill up to minimum length
        state_fcs_1,
        state_fcs_2,   // second block when the FCS spills over
        state_err,
        state_gap
    } framer_state_t;

endpackage

// ==== verilog/baser_tx_input.sv ====
// one-word holding stage; s_keep must be contiguous from bit 0 and all ones except on the last beat
`include "baser_tx_cfg.svh"

module baser_tx_input (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  baser_tx_pkg::word_t       s_data,
    input  logic [`BASER_KEEP_W-1:0]  s_keep,
    input  logic                      s_last,
    input  logic                      s_user,
    input  logic                      s_valid,
    output logic                      s_ready,
    input  logic                      word_take,
    output logic                      word_valid,
    output baser_tx_pkg::word_t       word_data,
    output baser_tx_pkg::empty_t      word_empty,
    output logic                      word_last,
    output logic                      word_err
);

    logic                  ready_en;   // low until the first cycle out of reset
    baser_tx_pkg::word_t   masked_data;
    baser_tx_pkg::empty_t  keep_empty;
    logic                  accept;

    // a new beat may enter while the held one leaves
    assign s_ready = ready_en && (!word_valid || word_take);
    assign accept = s_valid && s_ready;

    assign keep_empty = baser_tx_pkg::empty_t'(`BASER_KEEP_W - $countones(s_keep));

    always_comb begin
        for (int i = 0; i < `BASER_KEEP_W; i++) begin
            masked_data[8*i +: 8] = s_keep[i] ? s_data[8*i +: 8] : 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            ready_en <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (accept) begin
                word_valid <= 1'b1;
            end else if (word_take) begin
                word_valid <= 1'b0;
            end
        end
    end

    // payload side of the holding register
    always_ff @(posedge clk) begin
        if (accept) begin
            word_data <= masked_data;
            word_empty <= keep_empty;
            word_last <= s_last;
            word_err <= s_user;
        end
    end

endmodule

// ==== verilog/baser_tx_crc.sv ====
// byte-serial CRC-32 unrolled over one word; crc_part[n] covers bytes 0..n of crc_data
`include "baser_tx_cfg.svh"

module baser_tx_crc (
    input  logic                 clk,
    input  logic                 reset_crc,
    input  baser_tx_pkg::word_t  crc_data,
    input  logic                 crc_init,
    input  logic                 crc_advance,
    output logic [7:0][31:0]     crc_part
);

    function automatic logic [31:0] reverse32(input logic [31:0] v);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = v[31-i];
        end
        return r;
    endfunction

    localparam logic [31:0] poly_rev = reverse32(`BASER_CRC_POLY);

    // one byte into the reflected register, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] b);
        logic [31:0] r;
        r = c ^ {24'd0, b};
        for (int k = 0; k < 8; k++) begin
            if (r[0]) begin
                r = (r >> 1) ^ poly_rev;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    logic [31:0] crc_state;   // running value over full words

    always_comb begin
        crc_part[0] = crc_byte(crc_state, crc_data[7:0]);
        for (int n = 1; n < 8; n++) begin
            crc_part[n] = crc_byte(crc_part[n-1], crc_data[8*n +: 8]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc || crc_init) begin
            crc_state <= '1;
        end else if (crc_advance) begin
            crc_state <= crc_part[7];   // whole word consumed
        end
    end

endmodule

// ==== verilog/baser_tx_framer.sv ====
// frame sequencer; start always in lane 0, gap fixed by the build-time IFG, no length limit check
`include "baser_tx_cfg.svh"

module baser_tx_framer (
    input  logic                              clk,
    input  logic                              reset_crc,
    input  logic                              word_valid,
    input  baser_tx_pkg::word_t               word_data,
    input  baser_tx_pkg::empty_t              word_empty,
    input  logic                              word_last,
    input  logic                              word_err,
    output logic                              word_take,
    output baser_tx_pkg::block_kind_t         block_kind,
    output baser_tx_pkg::word_t               block_data
);

    // payload bytes before the FCS
    localparam int min_data_len = `BASER_MIN_FRAME_LEN - 4;

    function automatic baser_tx_pkg::block_kind_t term_kind(input logic [2:0] n);
        return baser_tx_pkg::block_kind_t'({1'b1, n});
    endfunction

    baser_tx_pkg::framer_state_t  state, state_next;
    baser_tx_pkg::word_t          data_reg, data_next;     // word being emitted
    baser_tx_pkg::empty_t         empty_reg, empty_next;
    logic                         err_reg, err_next;       // user error seen in this frame
    logic                         frame_reg, frame_next;   // beats of the frame still due
    logic [6:0]                   rem_reg, rem_next, rem_after;
    logic [7:0]                   ifg_reg, ifg_next;
    baser_tx_pkg::block_kind_t    kind_next;
    baser_tx_pkg::word_t          bdata_next;
    logic                         load;
    logic                         drain_done;
    logic                         crc_init;
    logic                         crc_advance;
    logic [7:0][31:0]             crc_part;
    logic [31:0]                  fcs;
    logic [127:0]                 fcs_ext;

    baser_tx_crc crc0 (
        .clk         (clk),
        .reset_crc   (reset_crc),
        .crc_data    (data_reg),
        .crc_init    (crc_init),
        .crc_advance (crc_advance),
        .crc_part    (crc_part)
    );

    // FCS packed right after the last valid byte, may spill into a second block
    assign fcs = ~crc_part[3'd7 - empty_reg];
    assign fcs_ext = {64'd0, data_reg} | ({96'd0, fcs} << (8 * (8 - empty_reg)));

    assign drain_done = !frame_reg || (word_valid && word_last);

    always_comb begin
        state_next = state;
        data_next = data_reg;
        empty_next = empty_reg;
        err_next = err_reg;
        frame_next = frame_reg;
        rem_next = rem_reg;
        ifg_next = ifg_reg;
        kind_next = baser_tx_pkg::kind_idle;
        bdata_next = data_reg;
        word_take = word_valid && frame_reg;   // drop leftover beats
        load = 1'b0;
        crc_init = 1'b0;
        crc_advance = 1'b0;
        rem_after = (rem_reg > 7'd8) ? rem_reg - 7'd8 : 7'd0;

        case (state)
            baser_tx_pkg::state_idle: begin
                crc_init = 1'b1;
                err_next = 1'b0;
                rem_after = 7'(min_data_len);   // start block holds no frame bytes
                word_take = word_valid;
                if (word_valid) begin
                    kind_next = baser_tx_pkg::kind_start;
                    bdata_next = {`BASER_SFD, {7{`BASER_PRE}}};
                    load = 1'b1;
                end
            end
            baser_tx_pkg::state_payload: begin
                kind_next = baser_tx_pkg::kind_data;
                crc_advance = 1'b1;
                word_take = word_valid;
                if (word_valid) begin
                    load = 1'b1;
                end else begin
                    state_next = baser_tx_pkg::state_err;   // underflow
                end
            end
            baser_tx_pkg::state_pad: begin
                kind_next = baser_tx_pkg::kind_data;
                crc_advance = 1'b1;
                data_next = '0;
                rem_next = rem_after;
                if (rem_after > 7'd8) begin
                    empty_next = '0;
                end else begin
                    empty_next = 3'(8 - rem_after);
                    state_next = baser_tx_pkg::state_fcs_1;
                end
            end
            baser_tx_pkg::state_fcs_1: begin
                bdata_next = fcs_ext[63:0];
                if (empty_reg >= 3'd5) begin
                    kind_next = term_kind(3'(12 - empty_reg));
                    ifg_next = 8'(`BASER_IFG_BYTES + 5) - 8'(empty_reg);
                    state_next = baser_tx_pkg::state_gap;
                end else begin
                    kind_next = baser_tx_pkg::kind_data;
                    state_next = baser_tx_pkg::state_fcs_2;
                end
            end
            baser_tx_pkg::state_fcs_2: begin
                bdata_next = fcs_ext[127:64];
                kind_next = term_kind(3'(4 - empty_reg));
                ifg_next = 8'(`BASER_IFG_BYTES - 3) - 8'(empty_reg);
                state_next = baser_tx_pkg::state_gap;
            end
            baser_tx_pkg::state_err: begin
                kind_next = baser_tx_pkg::kind_error;
                ifg_next = 8'(`BASER_IFG_BYTES);
                state_next = baser_tx_pkg::state_gap;
            end
            baser_tx_pkg::state_gap: begin
                ifg_next = (ifg_reg > 8'd8) ? ifg_reg - 8'd8 : 8'd0;
                if (ifg_next == 8'd0 && drain_done) begin
                    state_next = baser_tx_pkg::state_idle;
                end
            end
            default: begin
                state_next = baser_tx_pkg::state_idle;
            end
        endcase

        // route a fresh word by its last flag and the bytes still short of minimum
        if (load) begin
            data_next = word_data;
            empty_next = word_empty;
            err_next = err_next | word_err;
            rem_next = rem_after;
            if (!word_last) begin
                state_next = baser_tx_pkg::state_payload;
            end else if (err_next) begin
                state_next = baser_tx_pkg::state_err;
            end else if (rem_after > 7'd8) begin
                empty_next = '0;   // zero bytes already in place
                state_next = baser_tx_pkg::state_pad;
            end else begin
                if (rem_after != 7'd0 && word_empty > 3'(8 - rem_after)) begin
                    empty_next = 3'(8 - rem_after);
                end
                state_next = baser_tx_pkg::state_fcs_1;
            end
        end

        if (word_take) begin
            frame_next = !word_last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= baser_tx_pkg::state_idle;
            err_reg <= 1'b0;
            frame_reg <= 1'b0;
            rem_reg <= '0;
            ifg_reg <= '0;
            block_kind <= baser_tx_pkg::kind_idle;
        end else begin
            state <= state_next;
            err_reg <= err_next;
            frame_reg <= frame_next;
            rem_reg <= rem_next;
            ifg_reg <= ifg_next;
            block_kind <= kind_next;
        end
        data_reg <= data_next;
        empty_reg <= empty_next;
        block_data <= bdata_next;
    end

endmodule

// ==== verilog/baser_tx_encoder.sv ====
// 64b/66b block builder for lane-0 starts only; unknown kinds are sent as error blocks
`include "baser_tx_cfg.svh"

module baser_tx_encoder (
    input  logic                       clk,
    input  logic                       reset_crc,
    input  baser_tx_pkg::block_kind_t  block_kind,
    input  baser_tx_pkg::word_t        block_data,
    output baser_tx_pkg::word_t        encoded_data,
    output logic [`BASER_HDR_W-1:0]    encoded_hdr,
    output logic                       encoded_valid
);

    localparam logic [1:0] sync_data = 2'b10;
    localparam logic [1:0] sync_ctrl = 2'b01;

    localparam logic [6:0] ctrl_idle  = 7'h00;
    localparam logic [6:0] ctrl_error = 7'h1e;

    localparam logic [7:0] type_ctrl    = 8'h1e;
    localparam logic [7:0] type_start_0 = 8'h78;
    localparam logic [7:0] type_term_0  = 8'h87;
    localparam logic [7:0] type_term_1  = 8'h99;
    localparam logic [7:0] type_term_2  = 8'haa;
    localparam logic [7:0] type_term_3  = 8'hb4;
    localparam logic [7:0] type_term_4  = 8'hcc;
    localparam logic [7:0] type_term_5  = 8'hd2;
    localparam logic [7:0] type_term_6  = 8'he1;
    localparam logic [7:0] type_term_7  = 8'hff;

    localparam logic [63:0] idle_block  = {{8{ctrl_idle}}, type_ctrl};
    localparam logic [63:0] error_block = {{8{ctrl_error}}, type_ctrl};

    baser_tx_pkg::word_t d;

    assign d = block_data;

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            encoded_data <= idle_block;
            encoded_hdr <= sync_ctrl;
            encoded_valid <= 1'b0;
        end else begin
            encoded_valid <= 1'b1;
            encoded_hdr <= (block_kind == baser_tx_pkg::kind_data) ? sync_data : sync_ctrl;
            case (block_kind)
                baser_tx_pkg::kind_idle:   encoded_data <= idle_block;
                baser_tx_pkg::kind_error:  encoded_data <= error_block;
                baser_tx_pkg::kind_start:  encoded_data <= {d[63:8], type_start_0};
                baser_tx_pkg::kind_data:   encoded_data <= d;
                // data bytes low, then pad bits, then idle codes up to lane 7
                baser_tx_pkg::kind_term_0: encoded_data <= {{7{ctrl_idle}}, 7'd0, type_term_0};
                baser_tx_pkg::kind_term_1: begin
                    encoded_data <= {{6{ctrl_idle}}, 6'd0, d[7:0], type_term_1};
                end
                baser_tx_pkg::kind_term_2: begin
                    encoded_data <= {{5{ctrl_idle}}, 5'd0, d[15:0], type_term_2};
                end
                baser_tx_pkg::kind_term_3: begin
                    encoded_data <= {{4{ctrl_idle}}, 4'd0, d[23:0], type_term_3};
                end
                baser_tx_pkg::kind_term_4: begin
                    encoded_data <= {{3{ctrl_idle}}, 3'd0, d[31:0], type_term_4};
                end
                baser_tx_pkg::kind_term_5: begin
                    encoded_data <= {{2{ctrl_idle}}, 2'd0, d[39:0], type_term_5};
                end
                baser_tx_pkg::kind_term_6: begin
                    encoded_data <= {ctrl_idle, 1'b0, d[47:0], type_term_6};
                end
                baser_tx_pkg::kind_term_7: encoded_data <= {d[55:0], type_term_7};
                default:                   encoded_data <= error_block;
            endcase
        end
    end

endmodule

// ==== verilog/baser_tx_top.sv ====
// 10GBASE-R transmit path; output never stalls, so the source must keep up once a frame starts
`include "baser_tx_cfg.svh"

module baser_tx_top (
    input  logic                      clk,
    input  logic                      reset_crc,
    input  baser_tx_pkg::word_t       s_data,
    input  logic [`BASER_KEEP_W-1:0]  s_keep,
    input  logic                      s_last,
    input  logic                      s_user,
    input  logic                      s_valid,
    output logic                      s_ready,
    output baser_tx_pkg::word_t       encoded_data,
    output logic [`BASER_HDR_W-1:0]   encoded_hdr,
    output logic                      encoded_valid
);

    logic                       word_valid;
    baser_tx_pkg::word_t        word_data;
    baser_tx_pkg::empty_t       word_empty;
    logic                       word_last;
    logic                       word_err;
    logic                       word_take;
    baser_tx_pkg::block_kind_t  block_kind;
    baser_tx_pkg::word_t        block_data;

    baser_tx_input input0 (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .s_data     (s_data),
        .s_keep     (s_keep),
        .s_last     (s_last),
        .s_user     (s_user),
        .s_valid    (s_valid),
        .s_ready    (s_ready),
        .word_take  (word_take),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_empty (word_empty),
        .word_last  (word_last),
        .word_err   (word_err)
    );

    baser_tx_framer framer0 (
        .clk        (clk),
        .reset_crc  (reset_crc),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_empty (word_empty),
        .word_last  (word_last),
        .word_err   (word_err),
        .word_take  (word_take),
        .block_kind (block_kind),
        .block_data (block_data)
    );

    baser_tx_encoder encoder0 (
        .clk           (clk),
        .reset_crc     (reset_crc),
        .block_kind    (block_kind),
        .block_data    (block_data),
        .encoded_data  (encoded_data),
        .encoded_hdr   (encoded_hdr),
        .encoded_valid (encoded_valid)
    );

endmodule

// ==== test/baser_tx_assertions.sv ====
// port-level checks only; reset_crc must be high from time zero, fail_count is read by the testbench
`include "baser_tx_cfg.svh"

module baser_tx_assertions (
    input logic                    clk,
    input logic                    reset_crc,
    input logic                    s_ready,
    input logic [`BASER_HDR_W-1:0] encoded_hdr,
    input logic                    encoded_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // only the two legal sync headers on the line
    hdr_legal: assert property (@(posedge clk) disable iff (reset_crc)
        encoded_valid |-> (encoded_hdr == 2'b01 || encoded_hdr == 2'b10))
        else begin
            fail_count++;
            $error("encoded_hdr carries an illegal sync header");
        end

    valid_after_reset: assert property (@(posedge clk) $fell(reset_crc) |=> encoded_valid)
        else begin
            fail_count++;
            $error("encoded_valid did not rise after reset");
        end

    valid_held: assert property (@(posedge clk) disable iff (reset_crc)
        encoded_valid |=> encoded_valid)
        else begin
            fail_count++;
            $error("encoded_valid dropped after reset");
        end

    ready_in_reset: assert property (@(posedge clk) reset_crc |=> !s_ready)
        else begin
            fail_count++;
            $error("s_ready high while in reset");
        end

endmodule

bind baser_tx_top baser_tx_assertions assertions0 (.*);

// ==== test/baser_tx_tb.sv ====
// directed tests for lane-0 starts, 60-byte minimum payload and a 12-character gap after each T
`include "baser_tx_cfg.svh"

module baser_tx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                     clk;
    logic                     reset_crc;
    logic [`BASER_DATA_W-1:0] s_data;
    logic [`BASER_KEEP_W-1:0] s_keep;
    logic                     s_last;
    logic                     s_user;
    logic                     s_valid;
    logic                     s_ready;
    logic [`BASER_DATA_W-1:0] encoded_data;
    logic [`BASER_HDR_W-1:0]  encoded_hdr;
    logic                     encoded_valid;

    integer seed;
    int     errors = 0;
    int     words_queued = 0;
    int     cycles = 0;

    // expected frames in send order, bytes kept flat
    logic [7:0] exp_bytes[$];
    int         exp_len[$];
    bit         exp_err[$];
    string      exp_name[$];

    logic [7:0] rx[$];
    bit         in_frame = 1'b0;
    bit         gap_open = 1'b0;
    int         gap_chars = 0;
    int         nterm;

    baser_tx_top dut0 (
        .clk           (clk),
        .reset_crc     (reset_crc),
        .s_data        (s_data),
        .s_keep        (s_keep),
        .s_last        (s_last),
        .s_user        (s_user),
        .s_valid       (s_valid),
        .s_ready       (s_ready),
        .encoded_data  (encoded_data),
        .encoded_hdr   (encoded_hdr),
        .encoded_valid (encoded_valid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // ethernet FCS, bit at a time, lsb first
    function automatic logic [31:0] fcs_of(input logic [7:0] bytes[$]);
        logic [31:0] c;
        logic        fb;
        c = 32'hffffffff;
        foreach (bytes[i]) begin
            for (int k = 0; k < 8; k++) begin
                fb = c[0] ^ bytes[i][k];
                c = c >> 1;
                if (fb) c = c ^ 32'hedb88320;
            end
        end
        return ~c;
    endfunction

    function automatic int term_bytes(input logic [7:0] t);
        case (t)
            8'h87: return 0;
            8'h99: return 1;
            8'haa: return 2;
            8'hb4: return 3;
            8'hcc: return 4;
            8'hd2: return 5;
            8'he1: return 6;
            8'hff: return 7;
            default: return -1;
        endcase
    endfunction

    function automatic string current_name();
        return (exp_name.size() != 0) ? exp_name[0] : "no frame";
    endfunction

    // called right after a rising edge; stall_at drops s_valid before that word
    task automatic send_frame(input string name, input int len, input bit user, input int stall_at);
        logic [7:0]  payload[$];
        logic [7:0]  padded[$];
        logic [31:0] fcs;
        logic [63:0] data;
        logic [7:0]  keep;
        int          nwords;
        for (int i = 0; i < len; i++) payload.push_back(8'($random(seed)));
        padded = payload;
        while (padded.size() < `BASER_MIN_FRAME_LEN - 4) padded.push_back(8'h00);
        fcs = fcs_of(padded);
        for (int i = 0; i < 4; i++) padded.push_back(fcs[8*i +: 8]);   // little endian
        exp_name.push_back(name);
        exp_err.push_back(user || stall_at > 0);
        if (user || stall_at > 0) begin
            exp_len.push_back(0);
        end else begin
            exp_len.push_back(padded.size());
            foreach (padded[i]) exp_bytes.push_back(padded[i]);
        end
        words_queued += (padded.size() + 7) / 8 + 1;
        nwords = (len + 7) / 8;
        for (int w = 0; w < nwords; w++) begin
            if (stall_at > 0 && w == stall_at) begin
                s_valid <= 1'b0;
                repeat (3) @(posedge clk);
            end
            for (int k = 0; k < 8; k++) begin
                data[8*k +: 8] = (8*w + k < len) ? payload[8*w + k] : 8'hee;   // junk past keep
                keep[k] = (8*w + k < len);
            end
            s_data <= data;
            s_keep <= keep;
            s_last <= (w == nwords - 1);
            s_user <= user && (w == nwords - 1);
            s_valid <= 1'b1;
            @(posedge clk);
            while (!s_ready) @(posedge clk);
        end
    endtask

    task automatic end_burst();
        s_valid <= 1'b0;
        repeat (4) @(posedge clk);
    endtask

    task automatic test_reset();
        repeat (3) @(posedge clk);
        check("reset", 0, s_ready);
        check("reset", 0, encoded_valid);
        repeat (2) @(posedge clk);
        reset_crc <= 1'b0;
        @(posedge clk);
        repeat (8) begin
            @(posedge clk);
            check("reset", 1, encoded_valid);
            check("reset", 2'b01, encoded_hdr);
            check("reset", 64'h1e, encoded_data);   // idle fill
        end
    endtask

    task automatic test_frames();
        int lens[13];
        lens = '{60, 61, 63, 66, 67, 100, 101, 102, 103, 104, 105, 106, 107};
        foreach (lens[i]) send_frame($sformatf("frames len %0d", lens[i]), lens[i], 0, 0);
        end_burst();
    endtask

    task automatic test_padding();
        send_frame("padding len 1", 1, 0, 0);
        send_frame("padding len 17", 17, 0, 0);
        send_frame("padding len 59", 59, 0, 0);
        end_burst();
    endtask

    // s_valid stays high across frames
    task automatic test_gap();
        for (int i = 0; i < 8; i++) send_frame($sformatf("gap %0d", i), 64 + i, 0, 0);
        end_burst();
    endtask

    task automatic test_errors();
        send_frame("user error", 70, 1, 0);
        send_frame("after user error", 61, 0, 0);
        end_burst();
        send_frame("underflow", 90, 0, 3);
        send_frame("after underflow", 75, 0, 0);
        end_burst();
    endtask

    task automatic finish_frame(input bit got_err);
        string      name;
        int         len;
        bit         want_err;
        logic [7:0] b;
        if (exp_len.size() == 0) begin
            errors++;
            $display("A frame came out that was never sent");
            return;
        end
        name = exp_name.pop_front();
        len = exp_len.pop_front();
        want_err = exp_err.pop_front();
        check(name, want_err, got_err);
        if (!got_err) check(name, len, rx.size());
        for (int i = 0; i < len; i++) begin
            b = exp_bytes.pop_front();
            if (!got_err && i < rx.size()) check(name, b, rx[i]);
        end
    endtask

    // block decoder on pre-edge values
    always @(posedge clk) begin
        if (!reset_crc && encoded_valid) begin
            nterm = term_bytes(encoded_data[7:0]);
            if (encoded_hdr == 2'b10) begin
                for (int k = 0; k < 8; k++) rx.push_back(encoded_data[8*k +: 8]);
                if (!in_frame) begin
                    errors++;
                    $display("Data block seen outside a frame");
                end
            end else if (encoded_data[7:0] == 8'h78 && !in_frame) begin
                check(current_name(), 56'hd5555555555555, encoded_data[63:8]);
                if (gap_open) check(current_name(), 12, (gap_chars >= 12) ? 12 : gap_chars);
                rx.delete();
                in_frame = 1'b1;
                gap_open = 1'b0;
            end else if (nterm >= 0 && in_frame) begin
                for (int k = 0; k < nterm; k++) rx.push_back(encoded_data[8*(k+1) +: 8]);
                finish_frame(1'b0);
                in_frame = 1'b0;
                gap_open = 1'b1;
                gap_chars = 7 - nterm;   // idle lanes after T
            end else if (encoded_data == 64'h1e && !in_frame) begin
                gap_chars += 8;
            end else if (encoded_data == {{8{7'h1e}}, 8'h1e} && in_frame) begin
                finish_frame(1'b1);
                in_frame = 1'b0;
                gap_open = 1'b0;
            end else begin
                errors++;
                $display("Unexpected block %h with header %b", encoded_data, encoded_hdr);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < 2 * words_queued + 200) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout, the run did not finish within %0d cycles, %0d errors", cycles, errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        seed = 32'h6e14cccf;
        reset_crc = 1'b1;
        s_data = '0;
        s_keep = '0;
        s_last = 1'b0;
        s_user = 1'b0;
        s_valid = 1'b0;
        test_reset();
        test_frames();
        test_padding();
        test_gap();
        test_errors();
        while (exp_len.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);
        errors += dut0.assertions0.fail_count;
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/baser_tx_pkg.sv
verilog/baser_tx_input.sv
verilog/baser_tx_crc.sv
verilog/baser_tx_framer.sv
verilog/baser_tx_encoder.sv
verilog/baser_tx_top.sv
test/baser_tx_assertions.sv
test/baser_tx_tb.sv
